/* files.f */
+incdir+common
common/soc_pkg.sv
hw/addr_decoder.sv
sram/sram_bank_ctrl.sv
hw/bootrom.sv
hw/uart_regs.sv
hw/soc_bus_top.sv
verif/soc_bus_checker.sv
verif/soc_bus_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module soc_bus_tb -o soc_bus_sim

./obj_dir/soc_bus_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* verif/soc_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

// async read with oe_n low and a write at the clock edge
module sram_model #(
    parameter logic [15:0] FILL_TAG = 16'h0000
) (
    input  wire logic                    clk_i,
    input  wire logic [`SRAM_ADDR_W-1:0] addr_i,
    input  wire soc_pkg::word_t          wdata_i,
    output soc_pkg::word_t               rdata_o,
    input  wire logic [3:0]              be_n_i,
    input  wire logic                    ce_n_i,
    input  wire logic                    oe_n_i,
    input  wire logic                    we_n_i,
    input  wire logic                    data_oe_i
);

    soc_pkg::word_t mem [256];    // low 256 words only
    soc_pkg::word_t merged;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] <= {FILL_TAG, 8'(i), ~8'(i)};
        end
    end

    // write data only arrives while the controller drives the lines
    always @(posedge clk_i) begin
        if (!ce_n_i && !we_n_i && data_oe_i) begin
            merged = mem[addr_i[7:0]];
            for (int b = 0; b < 4; b++) begin
                if (!be_n_i[b]) merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
            mem[addr_i[7:0]] <= merged;
        end
    end

    assign rdata_o = (!ce_n_i && !oe_n_i) ? mem[addr_i[7:0]] : 32'hDEAD_BEEF;  // floating bus

endmodule

module soc_bus_tb;

    localparam int RESET_CYCLES    = 16;
    localparam int ROM_TXNS        = 40;
    localparam int RAM_TXNS        = 200;
    localparam int SPLIT_TXNS      = 40;
    localparam int SAME_TXNS       = 40;
    localparam int UART_TXNS       = 60;
    localparam int TOTAL_TXNS      = ROM_TXNS + RAM_TXNS + SPLIT_TXNS + SAME_TXNS + UART_TXNS;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_TXNS * 2 + RESET_CYCLES;

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic                    inst_req_i;
    soc_pkg::word_t          inst_addr_i;
    soc_pkg::word_t          inst_rdata_o;
    logic                    data_re_i;
    logic                    data_we_i;
    soc_pkg::word_t          data_addr_i;
    soc_pkg::word_t          data_wdata_i;
    soc_pkg::mask_t          data_mask_i;
    soc_pkg::word_t          data_rdata_o;
    logic                    stall_o;
    logic [`SRAM_ADDR_W-1:0] base_ram_addr_o;
    soc_pkg::word_t          base_ram_data_o;
    soc_pkg::word_t          base_ram_data_i;
    logic                    base_ram_data_oe_o;
    logic [3:0]              base_ram_be_n_o;
    logic                    base_ram_ce_n_o;
    logic                    base_ram_oe_n_o;
    logic                    base_ram_we_n_o;
    logic [`SRAM_ADDR_W-1:0] ext_ram_addr_o;
    soc_pkg::word_t          ext_ram_data_o;
    soc_pkg::word_t          ext_ram_data_i;
    logic                    ext_ram_data_oe_o;
    logic [3:0]              ext_ram_be_n_o;
    logic                    ext_ram_ce_n_o;
    logic                    ext_ram_oe_n_o;
    logic                    ext_ram_we_n_o;
    logic                    tx_valid_o;
    soc_pkg::byte_t          tx_byte_o;
    logic                    tx_busy_i = 1'b0;
    logic                    rx_valid_i = 1'b0;
    soc_pkg::byte_t          rx_byte_i = 8'h00;
    logic                    irq_o;

    logic                    rx_enable;
    soc_pkg::word_t          bg_rnd;
    int unsigned             first_draw;
    int                      errors;
    int                      checks;
    int                      errors_before;

    always #5 clk_i = ~clk_i;

    soc_bus_top DUT (.*);

    sram_model #(.FILL_TAG(16'hBA5E)) u_base_sram (
        .clk_i     (clk_i),
        .addr_i    (base_ram_addr_o),
        .wdata_i   (base_ram_data_o),
        .rdata_o   (base_ram_data_i),
        .be_n_i    (base_ram_be_n_o),
        .ce_n_i    (base_ram_ce_n_o),
        .oe_n_i    (base_ram_oe_n_o),
        .we_n_i    (base_ram_we_n_o),
        .data_oe_i (base_ram_data_oe_o)
    );

    sram_model #(.FILL_TAG(16'hE7E0)) u_ext_sram (
        .clk_i     (clk_i),
        .addr_i    (ext_ram_addr_o),
        .wdata_i   (ext_ram_data_o),
        .rdata_o   (ext_ram_data_i),
        .be_n_i    (ext_ram_be_n_o),
        .ce_n_i    (ext_ram_ce_n_o),
        .oe_n_i    (ext_ram_oe_n_o),
        .we_n_i    (ext_ram_we_n_o),
        .data_oe_i (ext_ram_data_oe_o)
    );

    soc_bus_checker u_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .inst_req_i     (inst_req_i),
        .inst_addr_i    (inst_addr_i),
        .inst_rdata_i   (inst_rdata_o),
        .data_re_i      (data_re_i),
        .data_we_i      (data_we_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_mask_i    (data_mask_i),
        .data_rdata_i   (data_rdata_o),
        .stall_i        (stall_o),
        .base_strobes_i ({base_ram_ce_n_o, base_ram_oe_n_o, base_ram_we_n_o, base_ram_data_oe_o}),
        .ext_strobes_i  ({ext_ram_ce_n_o, ext_ram_oe_n_o, ext_ram_we_n_o, ext_ram_data_oe_o}),
        .tx_valid_i     (tx_valid_o),
        .tx_byte_i      (tx_byte_o),
        .tx_busy_i      (tx_busy_i),
        .rx_valid_i     (rx_valid_i),
        .rx_byte_i      (rx_byte_i),
        .irq_i          (irq_o),
        .err_count_o    (errors),
        .check_count_o  (checks)
    );

    // serial line noise with rx only while enabled
    always @(posedge clk_i) begin
        bg_rnd = $urandom;
        tx_busy_i  <= bg_rnd[0];
        rx_valid_i <= rx_enable && (bg_rnd[3:1] == 3'd0);   // roughly one in eight
        rx_byte_i  <= bg_rnd[15:8];
    end

    function automatic soc_pkg::word_t ram_word_addr(input logic ext, input logic [7:0] idx);
        return (ext ? `EXT_RAM_BASE : `BASE_RAM_BASE) | {22'b0, idx, 2'b00};
    endfunction

    function automatic soc_pkg::word_t rom_word_addr(input logic [5:0] idx);
        return `BOOTROM_BASE | {24'b0, idx, 2'b00};
    endfunction

    // present one cpu request and hold it until an edge without stall
    task automatic run_txn(input logic ireq, input soc_pkg::word_t iaddr, input logic re,
                           input logic we, input soc_pkg::word_t daddr);
        soc_pkg::word_t rnd;
        rnd = $urandom;
        inst_req_i   <= ireq;
        inst_addr_i  <= iaddr;
        data_re_i    <= re;
        data_we_i    <= we;
        data_addr_i  <= daddr;
        data_wdata_i <= $urandom;
        data_mask_i  <= rnd[3:0];
        @(posedge clk_i);
        while (stall_o) @(posedge clk_i);
    endtask

    task automatic idle_bus();
        inst_req_i <= 1'b0;
        data_re_i  <= 1'b0;
        data_we_i  <= 1'b0;
        repeat (2) @(posedge clk_i);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d new errors, %0d checks so far",
                 num, name, errors - errors_before, checks);
        errors_before = errors;
    endtask

    initial begin
        soc_pkg::word_t r;
        first_draw = $urandom(46099);
        rst_n_i      <= 1'b0;
        inst_req_i   <= 1'b0;
        inst_addr_i  <= '0;
        data_re_i    <= 1'b0;
        data_we_i    <= 1'b0;
        data_addr_i  <= '0;
        data_wdata_i <= '0;
        data_mask_i  <= '0;
        rx_enable    <= 1'b0;
        errors_before = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        report_test(1, "reset state");

        for (int n = 0; n < ROM_TXNS; n++) begin
            r = $urandom;
            run_txn(r[16] | ~r[17], rom_word_addr(r[5:0]), r[17], 1'b0, rom_word_addr(r[13:8]));
        end
        idle_bus();
        report_test(2, "boot rom reads");

        for (int n = 0; n < RAM_TXNS; n++) begin
            r = $urandom;
            case (r[3:2])
                2'd0:    run_txn(1'b1, ram_word_addr(r[0], r[15:8]), 1'b0, 1'b0, '0);
                2'd1:    run_txn(1'b0, '0, 1'b1, 1'b0, ram_word_addr(r[0], r[15:8]));
                default: run_txn(1'b0, '0, 1'b0, 1'b1, ram_word_addr(r[0], r[15:8]));
            endcase
        end
        idle_bus();
        report_test(3, "single port sram");

        for (int n = 0; n < SPLIT_TXNS; n++) begin
            r = $urandom;
            run_txn(1'b1, ram_word_addr(r[0], r[15:8]), r[1], ~r[1],
                    ram_word_addr(~r[0], r[23:16]));
        end
        idle_bus();
        report_test(4, "split bank access");

        // same bank and sometimes the very same word
        for (int n = 0; n < SAME_TXNS; n++) begin
            r = $urandom;
            run_txn(1'b1, ram_word_addr(r[0], r[15:8]), r[1], ~r[1],
                    ram_word_addr(r[0], r[2] ? r[15:8] : r[23:16]));
        end
        idle_bus();
        report_test(5, "same bank conflict");

        rx_enable <= 1'b1;
        while (!irq_o) run_txn(1'b0, '0, 1'b1, 1'b0, `UART_STATUS_ADDR);
        for (int n = 0; n < UART_TXNS; n++) begin
            r = $urandom;
            case (r[2:0])
                3'd0, 3'd1: run_txn(1'b0, '0, 1'b1, 1'b0, `UART_STATUS_ADDR);
                3'd2:       run_txn(1'b0, '0, 1'b1, 1'b0, `UART_DATA_ADDR);
                3'd3:       run_txn(1'b0, '0, 1'b0, 1'b1, `UART_DATA_ADDR);
                3'd4:       run_txn(1'b0, '0, 1'b1, 1'b0, {4'h1, r[27:4], 4'h0});
                3'd5:       run_txn(1'b1, `UART_DATA_ADDR, 1'b0, 1'b0, '0);
                3'd6:       run_txn(1'b0, '0, 1'b0, 1'b1,
                                    r[8] ? `UART_STATUS_ADDR : rom_word_addr(r[13:8]));
                default:    run_txn(1'b0, '0, 1'b1, 1'b0, rom_word_addr(r[13:8]));
            endcase
        end
        rx_enable <= 1'b0;
        idle_bus();
        report_test(6, "serial and unmapped");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/soc_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module soc_bus_checker (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           inst_req_i,
    input  wire soc_pkg::word_t inst_addr_i,
    input  wire soc_pkg::word_t inst_rdata_i,
    input  wire logic           data_re_i,
    input  wire logic           data_we_i,
    input  wire soc_pkg::word_t data_addr_i,
    input  wire soc_pkg::word_t data_wdata_i,
    input  wire soc_pkg::mask_t data_mask_i,
    input  wire soc_pkg::word_t data_rdata_i,
    input  wire logic           stall_i,
    input  wire logic [3:0]     base_strobes_i,     // ce_n, oe_n, we_n, data_oe
    input  wire logic [3:0]     ext_strobes_i,
    input  wire logic           tx_valid_i,
    input  wire soc_pkg::byte_t tx_byte_i,
    input  wire logic           tx_busy_i,
    input  wire logic           rx_valid_i,
    input  wire soc_pkg::byte_t rx_byte_i,
    input  wire logic           irq_i,
    output int                  err_count_o,
    output int                  check_count_o
);

    soc_pkg::word_t   shadow_base [256];
    soc_pkg::word_t   shadow_ext  [256];
    logic             rx_ready_m;
    soc_pkg::byte_t   rx_byte_m;
    logic             stalled_m;        // last edge was the stall cycle
    int               base_we_seen;
    int               ext_we_seen;
    int               base_we_exp;
    int               ext_we_exp;
    soc_pkg::target_e inst_tgt;
    soc_pkg::target_e data_tgt;
    logic             exp_stall;
    logic             exp_tx;

    // same fill as the pin models
    initial begin
        for (int i = 0; i < 256; i++) begin
            shadow_base[i] = {16'hBA5E, 8'(i), ~8'(i)};
            shadow_ext[i]  = {16'hE7E0, 8'(i), ~8'(i)};
        end
    end

    // memory map as seen by the cpu
    function automatic soc_pkg::target_e decode(input soc_pkg::word_t addr, input logic req,
                                                input logic fetch);
        if (!req) return soc_pkg::TGT_NONE;
        if (addr[31:22] == 10'h200) return soc_pkg::TGT_BASE;
        if (addr[31:22] == 10'h201) return soc_pkg::TGT_EXT;
        if (addr[31:8] == 24'h9FC000) return soc_pkg::TGT_BOOTROM;
        if (fetch) return soc_pkg::TGT_NONE;   // no fetches from registers
        if ({addr[31:2], 2'b00} == `UART_DATA_ADDR) return soc_pkg::TGT_UART_DATA;
        if ({addr[31:2], 2'b00} == `UART_STATUS_ADDR) return soc_pkg::TGT_UART_STATUS;
        return soc_pkg::TGT_NONE;
    endfunction

    function automatic soc_pkg::word_t expect_read(input soc_pkg::target_e tgt,
                                                   input soc_pkg::word_t addr);
        case (tgt)
            soc_pkg::TGT_BASE:        return shadow_base[addr[9:2]];
            soc_pkg::TGT_EXT:         return shadow_ext[addr[9:2]];
            soc_pkg::TGT_BOOTROM:     return `BOOTROM_TAG | {26'b0, addr[7:2]};
            soc_pkg::TGT_UART_DATA:   return {24'b0, rx_byte_m};
            soc_pkg::TGT_UART_STATUS: return {30'b0, rx_ready_m, ~tx_busy_i};
            default:                  return '0;
        endcase
    endfunction

    function automatic soc_pkg::word_t merge_lanes(input soc_pkg::word_t old_w,
                                                   input soc_pkg::word_t new_w,
                                                   input soc_pkg::mask_t mask);
        soc_pkg::word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    task automatic compare(input string what, input soc_pkg::word_t got,
                           input soc_pkg::word_t exp);
        check_count_o++;
        if (got !== exp) begin
            err_count_o++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_ready_m = 1'b0;
            stalled_m  = 1'b0;
        end else begin
            inst_tgt  = decode(inst_addr_i, inst_req_i, 1'b1);
            data_tgt  = decode(data_addr_i, data_re_i | data_we_i, 1'b0);
            exp_stall = !stalled_m && (inst_tgt == data_tgt) &&
                        (inst_tgt == soc_pkg::TGT_BASE || inst_tgt == soc_pkg::TGT_EXT);
            exp_tx    = data_we_i && (data_tgt == soc_pkg::TGT_UART_DATA);
            compare("stall_o", {31'b0, stall_i}, {31'b0, exp_stall});
            compare("irq_o", {31'b0, irq_i}, {31'b0, rx_ready_m});
            compare("tx_valid_o", {31'b0, tx_valid_i}, {31'b0, exp_tx});
            if (exp_tx) begin
                compare("tx_byte_o", {24'b0, tx_byte_i}, {24'b0, data_wdata_i[7:0]});
            end
            if (!inst_req_i && !data_re_i && !data_we_i) begin
                compare("idle sram strobes", {24'b0, base_strobes_i, ext_strobes_i}, 32'hEE);
            end
            if (!base_strobes_i[1]) base_we_seen++;
            if (!ext_strobes_i[1]) ext_we_seen++;
            if (!stall_i) begin    // request completes at this edge
                if (data_re_i) begin
                    compare("data_rdata_o", data_rdata_i, expect_read(data_tgt, data_addr_i));
                    if (data_tgt == soc_pkg::TGT_UART_DATA) rx_ready_m = 1'b0;
                end
                if (data_we_i && data_tgt == soc_pkg::TGT_BASE) begin
                    shadow_base[data_addr_i[9:2]] =
                        merge_lanes(shadow_base[data_addr_i[9:2]], data_wdata_i, data_mask_i);
                    base_we_exp++;
                end
                if (data_we_i && data_tgt == soc_pkg::TGT_EXT) begin
                    shadow_ext[data_addr_i[9:2]] =
                        merge_lanes(shadow_ext[data_addr_i[9:2]], data_wdata_i, data_mask_i);
                    ext_we_exp++;
                end
                // fetch after a same-bank write sees the new word
                if (inst_req_i) begin
                    compare("inst_rdata_o", inst_rdata_i, expect_read(inst_tgt, inst_addr_i));
                end
                compare("base we_n pulses", base_we_seen, base_we_exp);
                compare("ext we_n pulses", ext_we_seen, ext_we_exp);
            end
            stalled_m = stall_i;
            if (rx_valid_i) begin   // new byte wins over a read at the same edge
                rx_ready_m = 1'b1;
                rx_byte_m  = rx_byte_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module soc_bus_top (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // cpu fetch port
    input  wire logic                  inst_req_i,
    input  wire soc_pkg::word_t        inst_addr_i,
    output soc_pkg::word_t             inst_rdata_o,

    // cpu data port
    input  wire logic                  data_re_i,
    input  wire logic                  data_we_i,
    input  wire soc_pkg::word_t        data_addr_i,
    input  wire soc_pkg::word_t        data_wdata_i,
    input  wire soc_pkg::mask_t        data_mask_i,
    output soc_pkg::word_t             data_rdata_o,
    output logic                       stall_o,

    // base sram
    output logic [`SRAM_ADDR_W-1:0]    base_ram_addr_o,
    output soc_pkg::word_t             base_ram_data_o,
    input  wire soc_pkg::word_t        base_ram_data_i,
    output logic                       base_ram_data_oe_o,
    output logic [3:0]                 base_ram_be_n_o,
    output logic                       base_ram_ce_n_o,
    output logic                       base_ram_oe_n_o,
    output logic                       base_ram_we_n_o,

    // ext sram
    output logic [`SRAM_ADDR_W-1:0]    ext_ram_addr_o,
    output soc_pkg::word_t             ext_ram_data_o,
    input  wire soc_pkg::word_t        ext_ram_data_i,
    output logic                       ext_ram_data_oe_o,
    output logic [3:0]                 ext_ram_be_n_o,
    output logic                       ext_ram_ce_n_o,
    output logic                       ext_ram_oe_n_o,
    output logic                       ext_ram_we_n_o,

    // serial
    output logic                       tx_valid_o,
    output soc_pkg::byte_t             tx_byte_o,
    input  wire logic                  tx_busy_i,
    input  wire logic                  rx_valid_i,
    input  wire soc_pkg::byte_t        rx_byte_i,
    output logic                       irq_o
);

    soc_pkg::target_e inst_tgt;
    soc_pkg::target_e data_tgt;

    logic base_stall;
    logic ext_stall;
    logic uart_hit;

    soc_pkg::word_t base_inst_rdata;
    soc_pkg::word_t base_data_rdata;
    soc_pkg::word_t ext_inst_rdata;
    soc_pkg::word_t ext_data_rdata;
    soc_pkg::word_t rom_inst_rdata;
    soc_pkg::word_t rom_data_rdata;
    soc_pkg::word_t uart_rdata;

    addr_decoder u_inst_dec (
        .addr_i      (inst_addr_i),
        .req_i       (inst_req_i),
        .inst_only_i (1'b1),
        .target_o    (inst_tgt)
    );

    addr_decoder u_data_dec (
        .addr_i      (data_addr_i),
        .req_i       (data_re_i | data_we_i),
        .inst_only_i (1'b0),
        .target_o    (data_tgt)
    );

    sram_bank_ctrl u_base_bank (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .inst_req_i    (inst_tgt == soc_pkg::TGT_BASE),
        .inst_addr_i   (inst_addr_i),
        .inst_rdata_o  (base_inst_rdata),
        .data_re_i     (data_re_i && (data_tgt == soc_pkg::TGT_BASE)),
        .data_we_i     (data_we_i && (data_tgt == soc_pkg::TGT_BASE)),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_mask_i   (data_mask_i),
        .data_rdata_o  (base_data_rdata),
        .stall_o       (base_stall),
        .ram_addr_o    (base_ram_addr_o),
        .ram_data_o    (base_ram_data_o),
        .ram_data_i    (base_ram_data_i),
        .ram_data_oe_o (base_ram_data_oe_o),
        .ram_be_n_o    (base_ram_be_n_o),
        .ram_ce_n_o    (base_ram_ce_n_o),
        .ram_oe_n_o    (base_ram_oe_n_o),
        .ram_we_n_o    (base_ram_we_n_o)
    );

    sram_bank_ctrl u_ext_bank (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .inst_req_i    (inst_tgt == soc_pkg::TGT_EXT),
        .inst_addr_i   (inst_addr_i),
        .inst_rdata_o  (ext_inst_rdata),
        .data_re_i     (data_re_i && (data_tgt == soc_pkg::TGT_EXT)),
        .data_we_i     (data_we_i && (data_tgt == soc_pkg::TGT_EXT)),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_mask_i   (data_mask_i),
        .data_rdata_o  (ext_data_rdata),
        .stall_o       (ext_stall),
        .ram_addr_o    (ext_ram_addr_o),
        .ram_data_o    (ext_ram_data_o),
        .ram_data_i    (ext_ram_data_i),
        .ram_data_oe_o (ext_ram_data_oe_o),
        .ram_be_n_o    (ext_ram_be_n_o),
        .ram_ce_n_o    (ext_ram_ce_n_o),
        .ram_oe_n_o    (ext_ram_oe_n_o),
        .ram_we_n_o    (ext_ram_we_n_o)
    );

    // read-only, writes to it just fall away
    bootrom u_bootrom (
        .inst_addr_i  (inst_addr_i),
        .inst_rdata_o (rom_inst_rdata),
        .data_addr_i  (data_addr_i),
        .data_rdata_o (rom_data_rdata)
    );

    assign uart_hit = (data_tgt == soc_pkg::TGT_UART_DATA) ||
                      (data_tgt == soc_pkg::TGT_UART_STATUS);

    uart_regs u_uart (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .read_i       (data_re_i && uart_hit),
        .write_i      (data_we_i && (data_tgt == soc_pkg::TGT_UART_DATA)),
        .status_sel_i (data_tgt == soc_pkg::TGT_UART_STATUS),
        .wdata_i      (data_wdata_i[7:0]),
        .rdata_o      (uart_rdata),
        .tx_valid_o   (tx_valid_o),
        .tx_byte_o    (tx_byte_o),
        .tx_busy_i    (tx_busy_i),
        .rx_valid_i   (rx_valid_i),
        .rx_byte_i    (rx_byte_i),
        .irq_o        (irq_o)
    );

    // only one bank can stall at a time, fetch and data share at most one
    assign stall_o = base_stall | ext_stall;

    always_comb begin
        case (inst_tgt)
            soc_pkg::TGT_BASE:    inst_rdata_o = base_inst_rdata;
            soc_pkg::TGT_EXT:     inst_rdata_o = ext_inst_rdata;
            soc_pkg::TGT_BOOTROM: inst_rdata_o = rom_inst_rdata;
            default:              inst_rdata_o = '0;
        endcase
    end

    always_comb begin
        case (data_tgt)
            soc_pkg::TGT_BASE:        data_rdata_o = base_data_rdata;
            soc_pkg::TGT_EXT:         data_rdata_o = ext_data_rdata;
            soc_pkg::TGT_BOOTROM:     data_rdata_o = rom_data_rdata;
            soc_pkg::TGT_UART_DATA,
            soc_pkg::TGT_UART_STATUS: data_rdata_o = uart_rdata;
            default:                  data_rdata_o = '0;   // unmapped
        endcase
    end

endmodule

`default_nettype wire

/* hw/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,

    // register access from the bus
    input  wire logic           read_i,
    input  wire logic           write_i,
    input  wire logic           status_sel_i,   // 1 = status, 0 = data
    input  wire soc_pkg::byte_t wdata_i,
    output soc_pkg::word_t      rdata_o,

    // serial side
    output logic                tx_valid_o,
    output soc_pkg::byte_t      tx_byte_o,
    input  wire logic           tx_busy_i,
    input  wire logic           rx_valid_i,
    input  wire soc_pkg::byte_t rx_byte_i,
    output logic                irq_o
);

    soc_pkg::byte_t rx_byte_q;
    logic           rx_ready_q;

    always_ff @(posedge clk_i) begin
        if (rx_valid_i) begin
            rx_byte_q <= rx_byte_i;
        end
    end

    // a new byte beats a read in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_ready_q <= 1'b0;
        end else if (rx_valid_i) begin
            rx_ready_q <= 1'b1;
        end else if (read_i && !status_sel_i) begin
            rx_ready_q <= 1'b0;
        end
    end

    always_comb begin
        if (status_sel_i) begin
            rdata_o = {30'b0, rx_ready_q, ~tx_busy_i};
        end else begin
            rdata_o = {24'b0, rx_byte_q};
        end
    end

    assign tx_valid_o = write_i && !status_sel_i;
    assign tx_byte_o  = wdata_i;
    assign irq_o      = rx_ready_q;  // level, held until the byte is read

endmodule

`default_nettype wire

/* hw/bootrom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module bootrom (
    input  wire soc_pkg::word_t inst_addr_i,
    output soc_pkg::word_t      inst_rdata_o,
    input  wire soc_pkg::word_t data_addr_i,
    output soc_pkg::word_t      data_rdata_o
);

    localparam int IDX_W = $clog2(`BOOTROM_DEPTH);

    soc_pkg::word_t rom_table [`BOOTROM_DEPTH];

    logic [IDX_W-1:0] inst_idx;
    logic [IDX_W-1:0] data_idx;

    // tag in the upper bits, word index in the low byte
    for (genvar gi = 0; gi < `BOOTROM_DEPTH; gi++) begin : g_rom
        assign rom_table[gi] = `BOOTROM_TAG | 32'(gi);
    end

    // byte address to word offset
    assign inst_idx = inst_addr_i[IDX_W+1:2];
    assign data_idx = data_addr_i[IDX_W+1:2];

    // two independent read ports
    assign inst_rdata_o = rom_table[inst_idx];
    assign data_rdata_o = rom_table[data_idx];

endmodule

`default_nettype wire

/* sram/sram_bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module sram_bank_ctrl (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,

    // fetch side
    input  wire logic                      inst_req_i,
    input  wire soc_pkg::word_t            inst_addr_i,
    output soc_pkg::word_t                 inst_rdata_o,

    // load/store side
    input  wire logic                      data_re_i,
    input  wire logic                      data_we_i,
    input  wire soc_pkg::word_t            data_addr_i,
    input  wire soc_pkg::word_t            data_wdata_i,
    input  wire soc_pkg::mask_t            data_mask_i,
    output soc_pkg::word_t                 data_rdata_o,

    output logic                           stall_o,

    // sram pins
    output logic [`SRAM_ADDR_W-1:0]        ram_addr_o,
    output soc_pkg::word_t                 ram_data_o,
    input  wire soc_pkg::word_t            ram_data_i,
    output logic                           ram_data_oe_o,
    output logic [3:0]                     ram_be_n_o,
    output logic                           ram_ce_n_o,
    output logic                           ram_oe_n_o,
    output logic                           ram_we_n_o
);

    soc_pkg::bank_phase_e phase_q;
    soc_pkg::bank_phase_e phase_d;
    soc_pkg::word_t       data_hold_q;    // data read from the conflict cycle

    logic data_req;
    logic conflict;
    logic serve_data;
    logic serve_inst;

    assign data_req = data_re_i | data_we_i;
    assign conflict = inst_req_i & data_req;

    // data always wins the first cycle, fetch goes when data is absent or done
    assign serve_data = (phase_q == soc_pkg::PH_IDLE) && data_req;
    assign serve_inst = inst_req_i && ((phase_q == soc_pkg::PH_INST_PENDING) || !data_req);

    assign stall_o = (phase_q == soc_pkg::PH_IDLE) && conflict;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            soc_pkg::PH_IDLE: begin
                if (conflict) begin
                    phase_d = soc_pkg::PH_INST_PENDING;
                end
            end
            default: phase_d = soc_pkg::PH_IDLE;  // fetch served this cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            phase_q <= soc_pkg::PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // keep the load result while the fetch takes the pins
    always_ff @(posedge clk_i) begin
        if (stall_o && data_re_i) begin
            data_hold_q <= ram_data_i;
        end
    end

    always_comb begin
        ram_addr_o    = inst_addr_i[`SRAM_ADDR_W+1:2];
        ram_data_o    = data_wdata_i;
        ram_data_oe_o = 1'b0;
        ram_be_n_o    = 4'b1111;
        ram_ce_n_o    = 1'b1;
        ram_oe_n_o    = 1'b1;
        ram_we_n_o    = 1'b1;
        if (serve_data) begin
            ram_addr_o = data_addr_i[`SRAM_ADDR_W+1:2];
            ram_ce_n_o = 1'b0;
            if (data_we_i) begin
                ram_be_n_o    = ~data_mask_i;
                ram_we_n_o    = 1'b0;
                ram_data_oe_o = 1'b1;
            end else begin
                ram_be_n_o = 4'b0000;
                ram_oe_n_o = 1'b0;
            end
        end else if (serve_inst) begin
            ram_ce_n_o = 1'b0;
            ram_oe_n_o = 1'b0;
            ram_be_n_o = 4'b0000;   // whole word for fetches
        end
    end

    assign inst_rdata_o = ram_data_i;
    assign data_rdata_o = (phase_q == soc_pkg::PH_INST_PENDING) ? data_hold_q : ram_data_i;

endmodule

`default_nettype wire

/* hw/addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module addr_decoder (
    input  wire soc_pkg::word_t addr_i,
    input  wire logic           req_i,
    input  wire logic           inst_only_i,    // fetch port, memory targets only
    output soc_pkg::target_e    target_o
);

    logic hit_base;
    logic hit_ext;
    logic hit_rom;
    logic hit_uart_data;
    logic hit_uart_status;

    assign hit_base        = (addr_i & `BASE_RAM_MASK) == `BASE_RAM_BASE;
    assign hit_ext         = (addr_i & `EXT_RAM_MASK) == `EXT_RAM_BASE;
    assign hit_rom         = (addr_i & `BOOTROM_MASK) == `BOOTROM_BASE;
    assign hit_uart_data   = (addr_i & `UART_REG_MASK) == `UART_DATA_ADDR;
    assign hit_uart_status = (addr_i & `UART_REG_MASK) == `UART_STATUS_ADDR;

    always_comb begin
        target_o = soc_pkg::TGT_NONE;
        if (req_i) begin
            if (hit_base) begin
                target_o = soc_pkg::TGT_BASE;
            end else if (hit_ext) begin
                target_o = soc_pkg::TGT_EXT;
            end else if (hit_rom) begin
                target_o = soc_pkg::TGT_BOOTROM;
            end else if (hit_uart_data && !inst_only_i) begin
                target_o = soc_pkg::TGT_UART_DATA;
            end else if (hit_uart_status && !inst_only_i) begin
                target_o = soc_pkg::TGT_UART_STATUS;
            end
        end
    end

endmodule

`default_nettype wire

/* common/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    typedef logic [31:0] word_t;    // address or data word
    typedef logic [3:0]  mask_t;    // set bit = lane written
    typedef logic [7:0]  byte_t;

    // where a decoded request goes
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_BASE,
        TGT_EXT,
        TGT_BOOTROM,
        TGT_UART_DATA,
        TGT_UART_STATUS
    } target_e;

    // bank controller phase
    typedef enum logic {
        PH_IDLE,            // nothing left over
        PH_INST_PENDING     // data half done, fetch still owed
    } bank_phase_e;

endpackage

`default_nettype wire

/* common/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// base sram, 4 MB window
`define BASE_RAM_BASE       32'h8000_0000
`define BASE_RAM_MASK       32'hFFC0_0000

// ext sram directly above base, also 4 MB
`define EXT_RAM_BASE        32'h8040_0000
`define EXT_RAM_MASK        32'hFFC0_0000

// boot rom, 256 bytes at the reset vector
`define BOOTROM_BASE        32'h9FC0_0000
`define BOOTROM_MASK        32'hFFFF_FF00

// serial registers, one word each
`define UART_DATA_ADDR      32'hBFD0_03F8
`define UART_STATUS_ADDR    32'hBFD0_03FC
`define UART_REG_MASK       32'hFFFF_FFFC

// word address into one bank (4 MB / 4 bytes)
`define SRAM_ADDR_W         20

// rom contents
`define BOOTROM_DEPTH       64
`define BOOTROM_TAG         32'hB007_0000

`endif
